//--- verification/core_mem_golden.txt
# op address size(0 byte, 1 half, 2 word) signed store_data expected_load
# R redirects fetch to the address, S ignores expected_load
L 00003000 2 0 00000000 A5A53000
L 00003001 0 1 00000000 00000030
L 00003002 0 1 00000000 FFFFFFA5
L 00003003 0 0 00000000 000000A5
L 00003002 1 1 00000000 FFFFA5A5
L 00003000 1 0 00000000 00003000
S 00003004 0 0 123456F1 00000000
S 00003005 0 0 00000082 00000000
R 00000400 0 0 00000000 00000000
S 00003006 0 0 0000007E 00000000
S 00003007 0 0 000000C3 00000000
L 00003004 2 0 00000000 C37E82F1
L 00003004 0 1 00000000 FFFFFFF1
L 00003005 0 0 00000000 00000082
L 00003006 0 1 00000000 0000007E
L 00003007 0 1 00000000 FFFFFFC3
S 00003008 1 0 ABCD8001 00000000
S 0000300A 1 0 00007FFE 00000000
R 00001000 0 0 00000000 00000000
L 00003008 2 0 00000000 7FFE8001
L 00003008 1 1 00000000 FFFF8001
L 00003008 1 0 00000000 00008001
L 0000300A 1 1 00000000 00007FFE
S 0000300C 2 0 DEADBEEF 00000000
L 0000300C 2 0 00000000 DEADBEEF

//--- list.f
rtl/core_mem_pkg.sv
rtl/fetch_queue.sv
rtl/load_store_unit.sv
rtl/mem_arbiter.sv
rtl/core_mem_top.sv
verification/mem_model.sv
verification/tb_core_mem.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and pass only if the pass line shows up
verilator --binary --timing --assert --timescale 1ns/1ns \
   -f list.f --top-module tb_core_mem -o sim_core_mem \
   && ./obj_dir/sim_core_mem | grep -x "TEST OK" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- verification/tb_core_mem.sv
// testbench for the core memory side, commands and expected loads come from the golden file
// a consumer process pops instructions while the main process runs loads, stores and redirects
`timescale 1ns/1ns
`default_nettype none

module tb_core_mem;

   import core_mem_pkg::*;

   localparam int unsigned WAIT_LIMIT = 200;
   localparam word_t       FILL_XOR   = 32'hA5A5_0000;

   logic        clk;
   logic        rst_n;
   logic        redirect;
   addr_t       redirect_pc;
   logic        inst_valid;
   fetch_word_t inst_out;
   logic        inst_take;
   logic        ls_start;
   ls_cmd_t     ls_cmd;
   logic        ls_busy;
   logic        ls_done;
   word_t       load_data;
   logic        mem_valid;
   mem_req_t    mem_req;
   logic        mem_ready;
   word_t       mem_rdata;

   // handshake between main process and consumer
   int unsigned redirect_seq;
   int unsigned redirect_seen;
   addr_t       redirect_target;
   logic        hold_take;
   int unsigned pop_count;
   addr_t       exp_pc;

   core_mem_top u_dut (.*);

   mem_model u_mem (.*);

   initial clk = 1'b0;
   always #4 clk = ~clk;

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   // contents of an untouched memory word
   function automatic word_t initial_word(input addr_t pc);
      return pc ^ FILL_XOR;
   endfunction

   task automatic wait_pops(input int unsigned pops);
      int unsigned start;
      int unsigned cycles;
      start  = pop_count;
      cycles = 0;
      while (pop_count < start + pops) begin
         @(negedge clk);
         cycles++;
         assert (cycles <= WAIT_LIMIT) else report_failure("instruction pops stalled");
      end
   endtask

   task automatic run_redirect(input addr_t target);
      int unsigned cycles;
      @(posedge clk);
      redirect_target = target;
      redirect_seq    = redirect_seq + 1;
      cycles          = 0;
      while (redirect_seen != redirect_seq) begin
         @(negedge clk);
         cycles++;
         assert (cycles <= WAIT_LIMIT) else report_failure("redirect was never issued");
      end
      // consumer checks this pop against the new target
      wait_pops(1);
   endtask

   task automatic run_load_store(input logic write, input addr_t addr, input logic [1:0] size,
                                 input logic sgn, input word_t wdata, input word_t expected);
      int unsigned cycles;
      @(negedge clk);
      assert (!ls_busy) else report_failure("ls_busy high before a new command");
      ls_start         = 1'b1;
      ls_cmd.address   = addr;
      ls_cmd.size      = access_size_e'(size);
      ls_cmd.is_signed = sgn;
      ls_cmd.write     = write;
      ls_cmd.wdata     = wdata;
      @(negedge clk);
      ls_start = 1'b0;
      cycles   = 0;
      while (!ls_done) begin
         @(negedge clk);
         cycles++;
         assert (cycles <= WAIT_LIMIT) else report_failure("ls_done did not arrive");
      end
      if (!write) begin
         assert (load_data == expected)
            else report_failure($sformatf("[ERROR] load_data at %h got %h expected %h",
                                          addr, load_data, expected));
      end
   endtask

   // ========================================
   // instruction consumer
   // ========================================
   initial begin
      redirect      = 1'b0;
      redirect_pc   = '0;
      inst_take     = 1'b0;
      exp_pc        = RESET_PC;
      redirect_seen <= 0;
      pop_count     <= 0;
      forever begin
         @(negedge clk);
         if (redirect_seen != redirect_seq) begin
            redirect      = 1'b1;
            redirect_pc   = redirect_target;
            inst_take     = 1'b0;
            exp_pc        = redirect_target;
            redirect_seen <= redirect_seq;
         end else begin
            redirect  = 1'b0;
            inst_take = !hold_take && ($urandom % 2 == 1);
            // entry shown now is popped at the next rising edge
            if (inst_valid && inst_take) begin
               assert (inst_out.pc == exp_pc)
                  else report_failure($sformatf("[ERROR] inst_out.pc got %h expected %h",
                                                inst_out.pc, exp_pc));
               assert (inst_out.inst == initial_word(exp_pc))
                  else report_failure($sformatf("[ERROR] inst_out.inst at %h got %h expected %h",
                                                exp_pc, inst_out.inst, initial_word(exp_pc)));
               exp_pc    = exp_pc + WORD_BYTES;
               pop_count <= pop_count + 1;
            end
         end
      end
   end

   // ========================================
   // main sequence
   // ========================================
   initial begin
      int            fd;
      int            fields;
      logic [7:0]    op;
      logic [1023:0] rest;
      addr_t         addr;
      logic [1:0]    size;
      logic          sgn;
      word_t         wdata;
      word_t         expected;

      void'($urandom(38));
      rst_n           = 1'b0;
      ls_start        = 1'b0;
      ls_cmd          = '0;
      redirect_seq    = 0;
      redirect_target = RESET_PC;
      hold_take       = 1'b0;
      repeat (10) @(negedge clk);
      assert (!mem_valid && !inst_valid && !ls_busy && !ls_done)
         else report_failure("outputs not idle during reset");
      rst_n = 1'b1;
      @(negedge clk);
      assert (mem_valid && mem_req.address == RESET_PC)
         else report_failure("first fetch to the reset address did not appear");

      fd = $fopen("verification/core_mem_golden.txt", "r");
      assert (fd != 0) else report_failure("cannot open the golden file");
      while ($fscanf(fd, "%s", op) == 1) begin
         if (op == "#") begin
            void'($fgets(rest, fd));
         end else begin
            fields = $fscanf(fd, "%h %d %d %h %h", addr, size, sgn, wdata, expected);
            assert (fields == 5) else report_failure("malformed line in the golden file");
            case (op)
               "L", "S": run_load_store(op == "S", addr, size, sgn, wdata, expected);
               "R":      run_redirect(addr);
               default:  report_failure("unknown command in the golden file");
            endcase
         end
      end
      $fclose(fd);

      // no pops for 30 cycles, queue fills and fetching stops
      @(posedge clk);
      hold_take = 1'b1;
      repeat (30) @(negedge clk);
      assert (inst_valid && !mem_valid)
         else report_failure("fetch did not stop with a full queue");
      @(posedge clk);
      hold_take = 1'b0;
      wait_pops(8);

      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

//--- verification/mem_model.sv
// memory model for the shared port, with random wait states
// words start at their address xor a fixed pattern, stores follow byte_sel
`timescale 1ns/1ns
`default_nettype none

module mem_model (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   mem_valid,
   input  core_mem_pkg::mem_req_t mem_req,
   output logic                   mem_ready,
   output core_mem_pkg::word_t    mem_rdata
);

   import core_mem_pkg::*;

   localparam int unsigned MEM_WORDS = 4096;
   localparam word_t       FILL_XOR  = 32'hA5A5_0000;

   // visible to the testbench by hierarchy
   word_t       mem [MEM_WORDS];
   logic [11:0] index;

   assign index     = mem_req.address[13:2];
   // read data follows the held request address
   assign mem_rdata = mem[index];

   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = (32'(i) << 2) ^ FILL_XOR;
      end
   end

   // roughly one cycle in four is a wait state
   always @(negedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem_ready <= 1'b0;
      end else begin
         mem_ready <= ($urandom % 4) != 0;
      end
   end

   // stores land on the enabled lanes only
   always @(posedge clk) begin
      if (mem_valid && mem_ready && mem_req.write) begin
         for (int b = 0; b < 4; b++) begin
            if (mem_req.byte_sel[b]) begin
               mem[index][8*b +: 8] <= mem_req.wdata[8*b +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/core_mem_top.sv
// memory side of the core: prefetch queue and load/store unit on one shared port
// the arbiter sits between both peers and the external memory bus
`timescale 1ns/1ns
`default_nettype none

module core_mem_top (
   input  logic                      clk,
   input  logic                      rst_n,
   // fetch side
   input  logic                      redirect,
   input  core_mem_pkg::addr_t       redirect_pc,
   output logic                      inst_valid,
   output core_mem_pkg::fetch_word_t inst_out,
   input  logic                      inst_take,
   // data side
   input  logic                      ls_start,
   input  core_mem_pkg::ls_cmd_t     ls_cmd,
   output logic                      ls_busy,
   output logic                      ls_done,
   output core_mem_pkg::word_t       load_data,
   // memory port
   output logic                      mem_valid,
   output core_mem_pkg::mem_req_t    mem_req,
   input  logic                      mem_ready,
   input  core_mem_pkg::word_t       mem_rdata
);

   import core_mem_pkg::*;

   logic     fetch_valid;
   logic     fetch_ready;
   mem_req_t fetch_req;
   logic     data_valid;
   logic     data_ready;
   mem_req_t data_req;

   fetch_queue u_fetch (
      .clk         (clk),
      .rst_n       (rst_n),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .inst_take   (inst_take),
      .fetch_ready (fetch_ready),
      .mem_rdata   (mem_rdata),
      .fetch_valid (fetch_valid),
      .fetch_req   (fetch_req),
      .inst_valid  (inst_valid),
      .inst_out    (inst_out)
   );

   load_store_unit u_lsu (
      .clk        (clk),
      .rst_n      (rst_n),
      .ls_start   (ls_start),
      .ls_cmd     (ls_cmd),
      .data_ready (data_ready),
      .mem_rdata  (mem_rdata),
      .data_valid (data_valid),
      .data_req   (data_req),
      .ls_busy    (ls_busy),
      .ls_done    (ls_done),
      .load_data  (load_data)
   );

   mem_arbiter u_arb (
      .clk         (clk),
      .rst_n       (rst_n),
      .fetch_valid (fetch_valid),
      .fetch_req   (fetch_req),
      .data_valid  (data_valid),
      .data_req    (data_req),
      .mem_ready   (mem_ready),
      .fetch_ready (fetch_ready),
      .data_ready  (data_ready),
      .mem_valid   (mem_valid),
      .mem_req     (mem_req)
   );

endmodule

`default_nettype wire

//--- rtl/mem_arbiter.sv
// two-way arbiter for the single memory port
// data side wins when idle, and a grant is kept until its access completes
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   fetch_valid,
   input  core_mem_pkg::mem_req_t fetch_req,
   input  logic                   data_valid,
   input  core_mem_pkg::mem_req_t data_req,
   input  logic                   mem_ready,
   output logic                   fetch_ready,
   output logic                   data_ready,
   output logic                   mem_valid,
   output core_mem_pkg::mem_req_t mem_req
);

   import core_mem_pkg::*;

   typedef enum logic [1:0] {
      ARB_IDLE,
      ARB_FETCH,
      ARB_DATA
   } arb_state_e;

   arb_state_e state;
   arb_state_e state_next;
   logic       grant_fetch;
   logic       grant_data;

   // ========================================
   // grant selection
   // ========================================
   always_comb begin
      grant_fetch = 1'b0;
      grant_data  = 1'b0;
      case (state)
         ARB_IDLE: begin
            grant_data  = data_valid;
            grant_fetch = fetch_valid & ~data_valid;
         end
         ARB_FETCH: grant_fetch = 1'b1;
         ARB_DATA:  grant_data  = 1'b1;
         default:   grant_fetch = 1'b0;
      endcase
   end

   assign mem_valid   = (grant_fetch & fetch_valid) | (grant_data & data_valid);
   assign mem_req     = grant_data ? data_req : fetch_req;
   assign fetch_ready = grant_fetch & fetch_valid & mem_ready;
   assign data_ready  = grant_data & data_valid & mem_ready;

   // lock the grant while the port waits
   always_comb begin
      state_next = state;
      case (state)
         ARB_IDLE: begin
            if (mem_valid && !mem_ready) begin
               state_next = grant_data ? ARB_DATA : ARB_FETCH;
            end
         end
         ARB_FETCH, ARB_DATA: begin
            if (mem_ready) begin
               state_next = ARB_IDLE;
            end
         end
         default: state_next = ARB_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ARB_IDLE;
      end else begin
         state <= state_next;
      end
   end

   // one peer finishes per port cycle
   assert property (@(posedge clk) disable iff (!rst_n)
      !(fetch_ready && data_ready));

endmodule

`default_nettype wire

//--- rtl/load_store_unit.sv
// load/store path toward the shared memory port
// places store bytes on their lanes and extends loaded bytes and halfwords
`timescale 1ns/1ns
`default_nettype none

module load_store_unit (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   ls_start,
   input  core_mem_pkg::ls_cmd_t  ls_cmd,
   input  logic                   data_ready,
   input  core_mem_pkg::word_t    mem_rdata,
   output logic                   data_valid,
   output core_mem_pkg::mem_req_t data_req,
   output logic                   ls_busy,
   output logic                   ls_done,
   output core_mem_pkg::word_t    load_data
);

   import core_mem_pkg::*;

   ls_cmd_t    cmd_r;
   logic [1:0] lane;
   word_t      store_lanes;
   byte_sel_t  store_sel;
   word_t      rdata_shift;
   word_t      load_ext;
   logic       complete;

   assign lane       = cmd_r.address[1:0];
   assign data_valid = ls_busy;
   assign complete   = data_valid & data_ready;

   // command is held for the whole access
   always_ff @(posedge clk) begin
      if (ls_start) begin
         cmd_r <= ls_cmd;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ls_busy <= 1'b0;
         ls_done <= 1'b0;
      end else begin
         ls_done <= complete;
         if (ls_start) begin
            ls_busy <= 1'b1;
         end else if (complete) begin
            ls_busy <= 1'b0;
         end
      end
   end

   // ========================================
   // store lane placement
   // ========================================
   always_comb begin
      case (cmd_r.size)
         SIZE_BYTE: begin
            store_lanes = {4{cmd_r.wdata[7:0]}};
            store_sel   = 4'b0001 << lane;
         end
         SIZE_HALF: begin
            store_lanes = {2{cmd_r.wdata[15:0]}};
            store_sel   = 4'b0011 << {lane[1], 1'b0};
         end
         default: begin
            store_lanes = cmd_r.wdata;
            store_sel   = 4'b1111;
         end
      endcase
   end

   // word aligned on the bus, loads read all four lanes
   always_comb begin
      data_req.address  = {cmd_r.address[31:2], 2'b00};
      data_req.write    = cmd_r.write;
      data_req.wdata    = store_lanes;
      data_req.byte_sel = cmd_r.write ? store_sel : 4'b1111;
   end

   // ========================================
   // load extraction
   // ========================================
   assign rdata_shift = mem_rdata >> {lane, 3'b000};

   always_comb begin
      case (cmd_r.size)
         SIZE_BYTE: load_ext = {{24{cmd_r.is_signed & rdata_shift[7]}}, rdata_shift[7:0]};
         SIZE_HALF: load_ext = {{16{cmd_r.is_signed & rdata_shift[15]}}, rdata_shift[15:0]};
         default:   load_ext = mem_rdata;
      endcase
   end

   always_ff @(posedge clk) begin
      if (complete && !cmd_r.write) begin
         load_data <= load_ext;
      end
   end

   // the core never issues misaligned halfword or word accesses
   assert property (@(posedge clk) disable iff (!rst_n)
      ls_start |-> !(ls_cmd.size == SIZE_HALF && ls_cmd.address[0])
                && !(ls_cmd.size == SIZE_WORD && ls_cmd.address[1:0] != 2'b00));

endmodule

`default_nettype wire

//--- rtl/fetch_queue.sv
// instruction prefetch with a four-entry queue in front of the core
// requests words on the shared port and flushes its contents on a redirect
`timescale 1ns/1ns
`default_nettype none

module fetch_queue (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      redirect,
   input  core_mem_pkg::addr_t       redirect_pc,
   input  logic                      inst_take,
   input  logic                      fetch_ready,
   input  core_mem_pkg::word_t       mem_rdata,
   output logic                      fetch_valid,
   output core_mem_pkg::mem_req_t    fetch_req,
   output logic                      inst_valid,
   output core_mem_pkg::fetch_word_t inst_out
);

   import core_mem_pkg::*;

   fetch_word_t         iq [IQ_DEPTH];
   logic [IQ_PTR_W-1:0] wr_ptr;
   logic [IQ_PTR_W-1:0] rd_ptr;
   // held entries plus the one outstanding fetch
   logic [IQ_PTR_W:0]   count;
   logic [IQ_PTR_W:0]   held;
   logic [IQ_PTR_W:0]   base;
   addr_t               next_pc;
   addr_t               req_pc;
   addr_t               launch_pc;
   logic                discard;
   logic                complete;
   logic                stay;
   logic                pop;
   logic                launch;

   // ========================================
   // occupancy and request decision
   // ========================================
   assign complete   = fetch_valid & fetch_ready;
   assign stay       = fetch_valid & ~fetch_ready;
   assign held       = count - {{IQ_PTR_W{1'b0}}, fetch_valid};
   assign inst_valid = (held != '0);
   assign inst_out   = iq[rd_ptr];
   // redirect wins over a pop
   assign pop        = inst_valid & inst_take & ~redirect;
   assign launch_pc  = redirect ? redirect_pc : next_pc;

   always_comb begin
      if (redirect) begin
         // only a fetch still waiting on the bus keeps its slot
         base = {{IQ_PTR_W{1'b0}}, stay};
      end else begin
         base = count - {{IQ_PTR_W{1'b0}}, pop}
                      - {{IQ_PTR_W{1'b0}}, complete & discard};
      end
      launch = ~stay & (base < IQ_DEPTH[IQ_PTR_W:0]);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fetch_valid <= 1'b0;
         count       <= '0;
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         discard     <= 1'b0;
         next_pc     <= RESET_PC;
         req_pc      <= RESET_PC;
      end else begin
         fetch_valid <= stay | launch;
         count       <= base + {{IQ_PTR_W{1'b0}}, launch};
         // in-flight word at a redirect completes on the bus but is dropped
         discard     <= redirect ? stay : (discard & ~complete);
         if (redirect) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
         end else begin
            if (complete && !discard) begin
               wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
         if (launch) begin
            req_pc  <= launch_pc;
            next_pc <= launch_pc + WORD_BYTES;
         end else if (redirect) begin
            next_pc <= redirect_pc;
         end
      end
   end

   // queue storage
   always_ff @(posedge clk) begin
      if (complete && !discard && !redirect) begin
         iq[wr_ptr] <= fetch_word_t'{pc: req_pc, inst: mem_rdata};
      end
   end

   // read-only word requests
   always_comb begin
      fetch_req          = '0;
      fetch_req.address  = req_pc;
      fetch_req.byte_sel = '1;
   end

   // ========================================
   // checks
   // ========================================
   // a waiting fetch keeps its address until the arbiter completes it
   assert property (@(posedge clk) disable iff (!rst_n)
      stay |=> fetch_valid && $stable(fetch_req.address));

   assert property (@(posedge clk) disable iff (!rst_n)
      count <= IQ_DEPTH[IQ_PTR_W:0]);

endmodule

`default_nettype wire

//--- rtl/core_mem_pkg.sv
// shared types and constants for the core memory side
// imported by the fetch queue, load/store unit, arbiter and top level
`default_nettype none

package core_mem_pkg;

   // ========================================
   // basic widths
   // ========================================
   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;
   typedef logic [3:0]  byte_sel_t;

   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } access_size_e;

   // ========================================
   // bundles
   // ========================================
   // one load or store from the core, store value in low bits of wdata
   typedef struct packed {
      addr_t        address;
      access_size_e size;
      logic         is_signed;
      logic         write;
      word_t        wdata;
   } ls_cmd_t;

   // request on the shared memory port
   typedef struct packed {
      addr_t     address;
      logic      write;
      word_t     wdata;
      byte_sel_t byte_sel;
   } mem_req_t;

   // instruction word with the address it came from
   typedef struct packed {
      addr_t pc;
      word_t inst;
   } fetch_word_t;

   // prefetch queue sizing
   localparam int unsigned IQ_DEPTH   = 4;
   localparam int unsigned IQ_PTR_W   = 2;
   localparam addr_t       RESET_PC   = 32'h0000_0000;
   localparam addr_t       WORD_BYTES = 32'd4;

endpackage

`default_nettype wire
